// File: sim.f
design/mips_isa_pkg.sv
design/mips_ctrl_pkg.sv
design/funct_decoder.sv
design/opcode_decoder.sv
design/control_sequencer.sv
design/mips_control.sv
verif/tb_mips_control.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_mips_control -f sim.f -o tb_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "no result in log"; exit 1; }
echo "simulation passed"
exit 0

// File: verif/tb_mips_control.sv
// testbench for the mips multicycle control path with directed decode under random memory stalls
`default_nettype none
`timescale 1ns/10ps

module tb_mips_control;

    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    logic             clk;
    logic             rst_n;
    logic             start;
    logic             waitrequest;
    instr_word_u      instr;
    ctrl_state_e      state;
    datapath_sel_t    sel;
    datapath_strobe_t strobe;

    logic             started;          // start already issued
    decode_t          exp_dec;
    datapath_sel_t    fetch_sel;
    datapath_strobe_t exp_exec1;
    datapath_strobe_t exp_exec2;
    int               errors;
    int               tests;
    int               errors_at_test;

    logic [5:0] r_functs [23] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_JR,
        FN_JALR, FN_MFHI, FN_MTHI, FN_MFLO, FN_MTLO, FN_MULT, FN_MULTU, FN_DIV, FN_DIVU,
        FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU};
    logic [5:0] imm_load_ops [12] = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI,
        OP_LUI, OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    logic [5:0] flow_ops [7] = '{OP_SW, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_J, OP_JAL};
    logic [4:0] regimm_rts [4] = '{RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL};
    logic [5:0] bad_ops [5] = '{6'b101000, 6'b101001, 6'b100010, 6'b100110, 6'b111111};

    mips_control u_mips_control (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .waitrequest (waitrequest),
        .instr       (instr),
        .state       (state),
        .sel         (sel),
        .strobe      (strobe)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // memory back-pressure about one cycle in three
    initial begin
        waitrequest = 1'b0;
        void'($urandom(32'h0d648f95));
        forever begin
            @(posedge clk);
            waitrequest <= ($urandom_range(2) == 0);
        end
    end

    // expected selections and requests per the decode tables
    function automatic decode_t expected_decode(input instr_word_u w);
        decode_t    e;
        logic [5:0] fn;
        logic [4:0] rt;
        e = '0;
        fn = w.r.funct;
        rt = w.i.rt;
        case (w.r.opcode)
            OP_RTYPE: begin
                e.sel.alu_op = ALU_RFUNC;
                e.sel.regdst = 1'b1;
                e.sel.jump = fn inside {FN_JR, FN_JALR};
                e.sel.regtojump = fn inside {FN_JR, FN_JALR};
                e.sel.link = (fn == FN_JALR);
                e.sel.hitoreg = (fn == FN_MFHI);
                e.sel.lotoreg = (fn == FN_MFLO);
                e.sel.div_mult_signed = fn inside {FN_MULT, FN_DIV};
                case (fn)
                    FN_MTLO:           e.sel.div_mult_op = MD_MTLO;
                    FN_MULT, FN_MULTU: e.sel.div_mult_op = MD_MULT;
                    FN_DIV, FN_DIVU:   e.sel.div_mult_op = MD_DIV;
                    default:           e.sel.div_mult_op = MD_MTHI;
                endcase
                e.want_md = fn inside {FN_MTHI, FN_MTLO, FN_MULT, FN_MULTU, FN_DIV, FN_DIVU};
                e.want_regwrite = fn inside {FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV,
                    FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU,
                    FN_MFHI, FN_MFLO, FN_JALR};
            end
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI: begin
                e.sel.alu_src = 1'b1;
                e.want_regwrite = 1'b1;
                case (w.r.opcode)
                    OP_ADDIU: e.sel.alu_op = ALU_ADD;
                    OP_SLTI:  e.sel.alu_op = ALU_SLT;
                    OP_SLTIU: e.sel.alu_op = ALU_SLTU;
                    OP_ANDI:  e.sel.alu_op = ALU_AND;
                    OP_ORI:   e.sel.alu_op = ALU_OR;
                    OP_XORI:  e.sel.alu_op = ALU_XOR;
                    default:  ;
                endcase
            end
            OP_LUI: begin
                e.sel.alu_src = 1'b1;
                e.sel.memtoreg = 1'b1;
                e.sel.loadimmed = 1'b1;
                e.want_memread = 1'b1;
                e.want_regwrite = 1'b1;
            end
            OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ: begin
                e.sel.branch = 1'b1;
                e.sel.alu_src = w.r.opcode inside {OP_BGTZ, OP_BLEZ};
                case (w.r.opcode)
                    OP_BEQ:  e.sel.alu_op = ALU_SUB_EQ;
                    OP_BNE:  e.sel.alu_op = ALU_NE;
                    OP_BGTZ: e.sel.alu_op = ALU_GTZ;
                    OP_BLEZ: e.sel.alu_op = ALU_LEZ;
                    default: ;
                endcase
            end
            OP_REGIMM: begin
                e.sel.branch = 1'b1;
                e.sel.alu_src = 1'b1;
                e.sel.alu_op = ALU_LTZ;
                e.sel.link = rt inside {RT_BLTZAL, RT_BGEZAL};
                e.want_regwrite = rt inside {RT_BLTZAL, RT_BGEZAL};
            end
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
                e.sel.alu_src = 1'b1;
                e.want_memread = 1'b1;
                e.want_regwrite = 1'b1;
                case (w.r.opcode)
                    OP_LB:   e.sel.extend_op = EXT_BYTE_S;
                    OP_LBU:  e.sel.extend_op = EXT_BYTE_U;
                    OP_LH:   e.sel.extend_op = EXT_HALF_S;
                    OP_LHU:  e.sel.extend_op = EXT_HALF_U;
                    default: e.sel.memtoreg = 1'b1;     // full word
                endcase
            end
            OP_SW: begin
                e.sel.alu_src = 1'b1;
                e.sel.regdst = 1'b1;
                e.want_memwrite = 1'b1;
            end
            OP_J: e.sel.jump = 1'b1;
            OP_JAL: begin
                e.sel.jump = 1'b1;
                e.sel.link = 1'b1;
                e.want_regwrite = 1'b1;
            end
            default: ;                                  // nop
        endcase
        return e;
    endfunction

    function automatic datapath_strobe_t strobe_of(input logic mr, input logic mw,
        input logic rw, input logic iw, input logic pw, input logic dm);
        datapath_strobe_t s;
        s.memread = mr;
        s.memwrite = mw;
        s.regwrite = rw;
        s.inwrite = iw;
        s.pcwrite = pw;
        s.div_mult_en = dm;
        return s;
    endfunction

    // rt aliases the BLTZAL code so only JALR may link
    function automatic instr_word_u make_r(input logic [5:0] fn);
        instr_word_u w;
        w.r = '{opcode: OP_RTYPE, rs: 5'd3, rt: 5'd16, rd: 5'd5, shamt: 5'd2, funct: fn};
        return w;
    endfunction

    // low immediate bits alias the JALR funct code
    function automatic instr_word_u make_i(input logic [5:0] op, input logic [4:0] rt_val);
        instr_word_u w;
        w.i = '{opcode: op, rs: 5'd6, rt: rt_val, imm: 16'h8009};
        return w;
    endfunction

    always_comb begin
        exp_dec = expected_decode(instr);
        fetch_sel = '0;
        fetch_sel.pctoadd = 1'b1;
        exp_exec1 = strobe_of(exp_dec.want_memread, 1'b0, 1'b0, 1'b0, 1'b0, exp_dec.want_md);
        exp_exec2 = strobe_of(1'b0, exp_dec.want_memwrite, exp_dec.want_regwrite, 1'b0,
            !waitrequest, 1'b0);
    end

    task automatic flag_value(input string name, input logic [31:0] got, input logic [31:0] want);
        errors++;
        $display("Error: %s = %h, expected %h at %0t", name, got, want, $time);
    endtask

    task automatic flag_event(input string what);
        errors++;
        $display("%s at %0t", what, $time);
    endtask

    // polls the state on falling edges
    task automatic wait_for_state(input ctrl_state_e target);
        int n;
        n = 0;
        while (state != target && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (state != target) begin
            $display("timeout waiting for state %s", target.name());
            $display("TESTBENCH FAILED");
            $finish;
        end
    endtask

    task automatic run_instr(input instr_word_u w);
        wait_for_state(FETCH);
        @(posedge clk);
        instr <= w;
        @(negedge clk);
        wait_for_state(EXEC2);
        wait_for_state(FETCH);
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - errors_at_test);
        errors_at_test = errors;
    endtask

    initial begin
        rst_n = 1'b0;
        start = 1'b0;
        instr = '0;
        started = 1'b0;
        errors = 0;
        tests = 0;
        errors_at_test = 0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);                  // idle in HALT a while
        start <= 1'b1;
        started <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        wait_for_state(FETCH);
        end_test("reset and start");
        for (int k = 0; k < 8; k++) begin
            run_instr((k % 2 == 0) ? make_r(FN_ADDU) : make_i(OP_LW, 5'd7));
        end
        end_test("sequencing under back-pressure");
        foreach (r_functs[k]) run_instr(make_r(r_functs[k]));
        end_test("r-type decode");
        foreach (imm_load_ops[k]) run_instr(make_i(imm_load_ops[k], 5'd7));
        end_test("immediates, lui and loads");
        foreach (flow_ops[k]) run_instr(make_i(flow_ops[k], 5'd7));
        foreach (regimm_rts[k]) run_instr(make_i(OP_REGIMM, regimm_rts[k]));
        end_test("stores, branches and jumps");
        foreach (bad_ops[k]) run_instr(make_i(bad_ops[k], 5'd7));
        end_test("unsupported opcodes");
        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    a_idle_until_start : assert property (@(posedge clk) !started |-> state == HALT)
        else flag_value("state", 32'($sampled(state)), 32'(HALT));

    a_start_to_fetch : assert property (@(posedge clk) disable iff (!rst_n)
        state == HALT && start |=> state == FETCH)
        else flag_event("start in HALT did not lead to FETCH");

    a_hold_on_wait : assert property (@(posedge clk) disable iff (!rst_n)
        state inside {FETCH, EXEC1, EXEC2} && waitrequest |=> $stable(state))
        else flag_event("state moved while waitrequest was high");

    a_fetch_advance : assert property (@(posedge clk) disable iff (!rst_n)
        state == FETCH && !waitrequest |=> state == DECODE)
        else flag_event("FETCH did not advance with waitrequest low");

    a_decode_once : assert property (@(posedge clk) disable iff (!rst_n)
        state == DECODE |=> state == EXEC1)
        else flag_event("DECODE did not last exactly one cycle");

    a_exec1_advance : assert property (@(posedge clk) disable iff (!rst_n)
        state == EXEC1 && !waitrequest |=> state == EXEC2)
        else flag_event("EXEC1 did not advance with waitrequest low");

    a_exec2_advance : assert property (@(posedge clk) disable iff (!rst_n)
        state == EXEC2 && !waitrequest |=> state == FETCH)
        else flag_event("EXEC2 did not return to FETCH with waitrequest low");

    a_halt_strobes : assert property (@(posedge clk) state == HALT |-> strobe == '0)
        else flag_value("strobe", 32'($sampled(strobe)), 32'h0);

    a_fetch_strobes : assert property (@(posedge clk)
        state == FETCH |-> strobe == strobe_of(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0))
        else flag_value("strobe", 32'($sampled(strobe)), 32'h20);

    a_decode_strobes : assert property (@(posedge clk)
        state == DECODE |-> strobe == strobe_of(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0))
        else flag_value("strobe", 32'($sampled(strobe)), 32'h04);

    a_exec1_strobes : assert property (@(posedge clk) state == EXEC1 |-> strobe == exp_exec1)
        else flag_value("strobe", 32'($sampled(strobe)), 32'($sampled(exp_exec1)));

    a_exec2_strobes : assert property (@(posedge clk) state == EXEC2 |-> strobe == exp_exec2)
        else flag_value("strobe", 32'($sampled(strobe)), 32'($sampled(exp_exec2)));

    a_fetch_sel : assert property (@(posedge clk)
        state inside {FETCH, DECODE} |-> sel == fetch_sel)
        else flag_value("sel", 32'($sampled(sel)), 32'($sampled(fetch_sel)));

    a_exec_sel : assert property (@(posedge clk)
        state inside {EXEC1, EXEC2} |-> sel == exp_dec.sel)
        else flag_value("sel", 32'($sampled(sel)), 32'($sampled(exp_dec.sel)));

endmodule

`default_nettype wire

// File: design/mips_control.sv
// mips control top, funct and opcode decoders feeding the multicycle sequencer
`default_nettype none
`timescale 1ns/10ps

module mips_control (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             start,        // one cycle, sampled in HALT
    input  wire                             waitrequest,
    input  wire mips_isa_pkg::instr_word_u  instr,        // instruction register contents
    output mips_ctrl_pkg::ctrl_state_e      state,
    output mips_ctrl_pkg::datapath_sel_t    sel,
    output mips_ctrl_pkg::datapath_strobe_t strobe
);

    import mips_ctrl_pkg::*;

    funct_info_t info;
    decode_t     dec;

    funct_decoder u_funct_decoder (
        .instr (instr),
        .info  (info)
    );

    opcode_decoder u_opcode_decoder (
        .instr (instr),
        .info  (info),
        .dec   (dec)
    );

    control_sequencer u_control_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .waitrequest (waitrequest),
        .dec         (dec),
        .state       (state),
        .sel         (sel),
        .strobe      (strobe)
    );

endmodule

`default_nettype wire

// File: design/control_sequencer.sv
// multicycle control sequencer, state register plus state-qualified selects and strobes
`default_nettype none
`timescale 1ns/10ps

module control_sequencer (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             start,
    input  wire                             waitrequest,
    input  wire mips_ctrl_pkg::decode_t     dec,
    output mips_ctrl_pkg::ctrl_state_e      state,
    output mips_ctrl_pkg::datapath_sel_t    sel,
    output mips_ctrl_pkg::datapath_strobe_t strobe
);

    import mips_ctrl_pkg::*;

    ctrl_state_e next_state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= HALT;
        end else begin
            state <= next_state;
        end
    end

    // memory-facing states stall on waitrequest
    always_comb begin
        next_state = state;
        case (state)
            HALT:    if (start) next_state = FETCH;
            FETCH:   if (!waitrequest) next_state = DECODE;
            DECODE:  next_state = EXEC1;
            EXEC1:   if (!waitrequest) next_state = EXEC2;
            EXEC2:   if (!waitrequest) next_state = FETCH;
            default: next_state = HALT;
        endcase
    end

    always_comb begin
        sel = '0;
        case (state)
            FETCH, DECODE: sel.pctoadd = 1'b1;  // pc addresses memory for the fetch
            EXEC1, EXEC2:  sel = dec.sel;
            default:       ;
        endcase
    end

    always_comb begin
        strobe.memread     = (state == FETCH) || (state == EXEC1 && dec.want_memread);
        strobe.inwrite     = (state == DECODE);
        strobe.div_mult_en = (state == EXEC1) && dec.want_md;
        strobe.regwrite    = (state == EXEC2) && dec.want_regwrite;
        strobe.memwrite    = (state == EXEC2) && dec.want_memwrite;
        strobe.pcwrite     = (state == EXEC2) && !waitrequest;  // pc moves as the instruction retires
    end

    a_pcwrite_in_exec2 : assert property (
        @(posedge clk) disable iff (!rst_n) strobe.pcwrite |-> state == EXEC2
    ) else $error("control_sequencer: pcwrite outside EXEC2");

    a_mem_exclusive : assert property (
        @(posedge clk) disable iff (!rst_n) !(strobe.memread && strobe.memwrite)
    ) else $error("control_sequencer: memread and memwrite together");

    a_decode_one_cycle : assert property (
        @(posedge clk) disable iff (!rst_n) state == DECODE |=> state == EXEC1
    ) else $error("control_sequencer: DECODE not followed by EXEC1");

endmodule

`default_nettype wire

// File: design/opcode_decoder.sv
// opcode decoder, maps the primary opcode to datapath selections and write requests
`default_nettype none
`timescale 1ns/10ps

module opcode_decoder (
    input  wire mips_isa_pkg::instr_word_u instr,
    input  wire mips_ctrl_pkg::funct_info_t info,
    output mips_ctrl_pkg::decode_t         dec
);

    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    function automatic alu_op_e imm_alu_op(input logic [5:0] op);
        alu_op_e res;
        case (op)
            OP_ANDI:  res = ALU_AND;
            OP_ORI:   res = ALU_OR;
            OP_XORI:  res = ALU_XOR;
            OP_SLTI:  res = ALU_SLT;
            OP_SLTIU: res = ALU_SLTU;
            default:  res = ALU_ADD;    // ADDIU
        endcase
        return res;
    endfunction

    function automatic extend_op_e load_ext(input logic [5:0] op);
        extend_op_e res;
        case (op)
            OP_LB:   res = EXT_BYTE_S;
            OP_LBU:  res = EXT_BYTE_U;
            OP_LH:   res = EXT_HALF_S;
            OP_LHU:  res = EXT_HALF_U;
            default: res = EXT_NONE;    // full word
        endcase
        return res;
    endfunction

    always_comb begin
        dec = '0;
        case (instr.r.opcode)
            OP_RTYPE: begin
                dec.sel.alu_op          = ALU_RFUNC;
                dec.sel.regdst          = 1'b1;
                dec.sel.jump            = info.regjump;
                dec.sel.regtojump       = info.regjump;
                dec.sel.div_mult_signed = info.md_signed;
                dec.sel.div_mult_op     = info.md_op;
                dec.sel.hitoreg         = info.hitoreg;
                dec.sel.lotoreg         = info.lotoreg;
                // rt of other r words may alias a regimm link code, keep JALR only
                dec.sel.link            = info.link & info.regjump & info.arith;
                dec.want_regwrite       = info.arith;
                dec.want_md             = info.mult_div;
            end
            OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_SLTIU: begin
                dec.sel.alu_op    = imm_alu_op(instr.i.opcode);
                dec.sel.alu_src   = 1'b1;
                dec.want_regwrite = 1'b1;
            end
            OP_LUI: begin
                dec.sel.alu_src   = 1'b1;
                dec.sel.memtoreg  = 1'b1;
                dec.sel.loadimmed = 1'b1;   // immediate shifted into the upper half
                dec.want_memread  = 1'b1;
                dec.want_regwrite = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                dec.sel.alu_op = (instr.i.opcode == OP_BEQ) ? ALU_SUB_EQ : ALU_NE;
                dec.sel.branch = 1'b1;
            end
            OP_BGTZ, OP_BLEZ: begin
                dec.sel.alu_op  = (instr.i.opcode == OP_BGTZ) ? ALU_GTZ : ALU_LEZ;
                dec.sel.alu_src = 1'b1;
                dec.sel.branch  = 1'b1;
            end
            OP_REGIMM: begin
                dec.sel.alu_op    = ALU_LTZ;
                dec.sel.alu_src   = 1'b1;
                dec.sel.branch    = 1'b1;
                // funct bits of a regimm word are immediate, so recheck rt
                dec.sel.link      = info.link & (instr.i.rt inside {RT_BLTZAL, RT_BGEZAL});
                dec.want_regwrite = dec.sel.link;
            end
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
                dec.sel.alu_src   = 1'b1;
                dec.sel.memtoreg  = (instr.i.opcode == OP_LW);
                dec.sel.extend_op = load_ext(instr.i.opcode);
                dec.want_memread  = 1'b1;
                dec.want_regwrite = 1'b1;
            end
            OP_SW: begin
                dec.sel.alu_src   = 1'b1;
                dec.sel.regdst    = 1'b1;
                dec.want_memwrite = 1'b1;
            end
            OP_J: begin
                dec.sel.jump = 1'b1;
            end
            OP_JAL: begin
                dec.sel.jump      = 1'b1;
                dec.sel.link      = 1'b1;   // return address to r31
                dec.want_regwrite = 1'b1;
            end
            default: ;                      // unsupported, behaves as a nop
        endcase

        assert (!(dec.want_memread && dec.want_memwrite))
            else $error("opcode_decoder: read and write requested together");
    end

endmodule

`default_nettype wire

// File: design/funct_decoder.sv
// function field decoder, classifies r-type funct codes and regimm link branches
`default_nettype none
`timescale 1ns/10ps

module funct_decoder (
    input  wire mips_isa_pkg::instr_word_u instr,
    output mips_ctrl_pkg::funct_info_t     info
);

    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    always_comb begin
        info = '0;
        case (instr.r.funct)
            FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV,
            FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU: begin
                info.arith = 1'b1;
            end
            FN_MFHI: begin
                info.arith   = 1'b1;
                info.hitoreg = 1'b1;
            end
            FN_MFLO: begin
                info.arith   = 1'b1;
                info.lotoreg = 1'b1;
            end
            FN_JR: begin
                info.regjump = 1'b1;
            end
            FN_JALR: begin
                info.arith   = 1'b1;     // return address written to rd
                info.regjump = 1'b1;
                info.link    = 1'b1;
            end
            FN_MTHI: begin
                info.mult_div = 1'b1;
                info.md_op    = MD_MTHI;
            end
            FN_MTLO: begin
                info.mult_div = 1'b1;
                info.md_op    = MD_MTLO;
            end
            FN_MULT, FN_MULTU: begin
                info.mult_div  = 1'b1;
                info.md_signed = (instr.r.funct == FN_MULT);
                info.md_op     = MD_MULT;
            end
            FN_DIV, FN_DIVU: begin
                info.mult_div  = 1'b1;
                info.md_signed = (instr.r.funct == FN_DIV);
                info.md_op     = MD_DIV;
            end
            default: ;                  // unknown funct, no class
        endcase

        // regimm view, opcode is qualified downstream
        case (instr.i.rt)
            RT_BLTZAL, RT_BGEZAL: info.link = 1'b1;
            RT_BLTZ, RT_BGEZ:     ;     // plain compare, no link
            default:              ;
        endcase

        assert (!(info.regjump && info.mult_div))
            else $error("funct_decoder: jump and mult/div classes overlap");
    end

endmodule

`default_nettype wire

// File: design/mips_ctrl_pkg.sv
// mips control package, state and operation encodings and the control bundles
`default_nettype none

package mips_ctrl_pkg;

    typedef enum logic [2:0] {
        HALT   = 3'd0,
        FETCH  = 3'd1,
        DECODE = 3'd2,
        EXEC1  = 3'd3,
        EXEC2  = 3'd4
    } ctrl_state_e;

    // alu control codes, ALU_RFUNC hands the choice to the funct field
    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0000,
        ALU_SUB_EQ = 4'b0001,
        ALU_RFUNC  = 4'b0010,
        ALU_AND    = 4'b0100,
        ALU_OR     = 4'b0101,
        ALU_XOR    = 4'b0110,
        ALU_SLT    = 4'b0111,
        ALU_NE     = 4'b1000,
        ALU_GTZ    = 4'b1001,
        ALU_LEZ    = 4'b1010,
        ALU_LTZ    = 4'b1011,
        ALU_SLTU   = 4'b1100
    } alu_op_e;

    // bit 2 enables extension, bit 1 picks byte over half, bit 0 picks signed
    typedef enum logic [2:0] {
        EXT_NONE   = 3'b000,
        EXT_HALF_U = 3'b100,
        EXT_HALF_S = 3'b101,
        EXT_BYTE_U = 3'b110,
        EXT_BYTE_S = 3'b111
    } extend_op_e;

    typedef enum logic [1:0] {
        MD_MTHI = 2'b00,
        MD_MTLO = 2'b01,
        MD_MULT = 2'b10,
        MD_DIV  = 2'b11
    } md_op_e;

    typedef struct packed {
        logic    arith;      // result goes to rd
        logic    regjump;
        logic    link;
        logic    mult_div;
        logic    md_signed;
        md_op_e  md_op;
        logic    hitoreg;
        logic    lotoreg;
    } funct_info_t;

    // selection fields, steady for the whole instruction
    typedef struct packed {
        alu_op_e    alu_op;
        logic       alu_src;         // immediate as second operand
        logic       jump;
        logic       branch;
        logic       regdst;
        logic       memtoreg;
        logic       pctoadd;         // pc drives the memory address
        logic       regtojump;
        logic       div_mult_signed;
        md_op_e     div_mult_op;
        logic       hitoreg;
        logic       lotoreg;
        logic       link;
        logic       loadimmed;
        extend_op_e extend_op;
    } datapath_sel_t;

    typedef struct packed {
        datapath_sel_t sel;
        logic          want_memread;
        logic          want_memwrite;
        logic          want_regwrite;
        logic          want_md;
    } decode_t;

    typedef struct packed {
        logic memread;
        logic memwrite;
        logic regwrite;
        logic inwrite;
        logic pcwrite;
        logic div_mult_en;
    } datapath_strobe_t;

endpackage

`default_nettype wire

// File: design/mips_isa_pkg.sv
// mips instruction set package, opcode/function/regimm encodings and instruction word views
`default_nettype none

package mips_isa_pkg;

    // primary opcodes, bits 31:26
    localparam logic [5:0] OP_RTYPE  = 6'b000000;
    localparam logic [5:0] OP_REGIMM = 6'b000001;
    localparam logic [5:0] OP_J      = 6'b000010;
    localparam logic [5:0] OP_JAL    = 6'b000011;
    localparam logic [5:0] OP_BEQ    = 6'b000100;
    localparam logic [5:0] OP_BNE    = 6'b000101;
    localparam logic [5:0] OP_BLEZ   = 6'b000110;
    localparam logic [5:0] OP_BGTZ   = 6'b000111;
    localparam logic [5:0] OP_ADDIU  = 6'b001001;
    localparam logic [5:0] OP_SLTI   = 6'b001010;
    localparam logic [5:0] OP_SLTIU  = 6'b001011;
    localparam logic [5:0] OP_ANDI   = 6'b001100;
    localparam logic [5:0] OP_ORI    = 6'b001101;
    localparam logic [5:0] OP_XORI   = 6'b001110;
    localparam logic [5:0] OP_LUI    = 6'b001111;
    localparam logic [5:0] OP_LB     = 6'b100000;
    localparam logic [5:0] OP_LH     = 6'b100001;
    localparam logic [5:0] OP_LW     = 6'b100011;
    localparam logic [5:0] OP_LBU    = 6'b100100;
    localparam logic [5:0] OP_LHU    = 6'b100101;
    localparam logic [5:0] OP_SW     = 6'b101011;

    // r-type function field, bits 5:0
    localparam logic [5:0] FN_SLL   = 6'b000000;
    localparam logic [5:0] FN_SRL   = 6'b000010;
    localparam logic [5:0] FN_SRA   = 6'b000011;
    localparam logic [5:0] FN_SLLV  = 6'b000100;
    localparam logic [5:0] FN_SRLV  = 6'b000110;
    localparam logic [5:0] FN_SRAV  = 6'b000111;
    localparam logic [5:0] FN_JR    = 6'b001000;
    localparam logic [5:0] FN_JALR  = 6'b001001;
    localparam logic [5:0] FN_MFHI  = 6'b010000;
    localparam logic [5:0] FN_MTHI  = 6'b010001;
    localparam logic [5:0] FN_MFLO  = 6'b010010;
    localparam logic [5:0] FN_MTLO  = 6'b010011;
    localparam logic [5:0] FN_MULT  = 6'b011000;
    localparam logic [5:0] FN_MULTU = 6'b011001;
    localparam logic [5:0] FN_DIV   = 6'b011010;
    localparam logic [5:0] FN_DIVU  = 6'b011011;
    localparam logic [5:0] FN_ADDU  = 6'b100001;
    localparam logic [5:0] FN_SUBU  = 6'b100011;
    localparam logic [5:0] FN_AND   = 6'b100100;
    localparam logic [5:0] FN_OR    = 6'b100101;
    localparam logic [5:0] FN_XOR   = 6'b100110;
    localparam logic [5:0] FN_SLT   = 6'b101010;
    localparam logic [5:0] FN_SLTU  = 6'b101011;

    // regimm branches select on the rt field
    localparam logic [4:0] RT_BLTZ   = 5'b00000;
    localparam logic [4:0] RT_BGEZ   = 5'b00001;
    localparam logic [4:0] RT_BLTZAL = 5'b10000;
    localparam logic [4:0] RT_BGEZAL = 5'b10001;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_word_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_word_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } j_word_t;

    // the same 32 bit word seen in each of the three formats
    typedef union packed {
        r_word_t r;
        i_word_t i;
        j_word_t j;
    } instr_word_u;

endpackage

`default_nettype wire
